// ==== flist.f ====
+incdir+include
verilog/ex_pkg.sv
verilog/alu_control.sv
verilog/alu.sv
verilog/ex_stage.sv
verilog/id_ex_reg.sv
verilog/ex_mem_reg.sv
verilog/ex_top.sv
sim/tb_ex_top.sv

// ==== include/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// Signed overflow of a + b, or of a - b when sub is set
function automatic logic ref_overflow(input ex_pkg::word_t a, input ex_pkg::word_t b,
                                      input logic sub);
    ex_pkg::word_t r;
    logic          bs;
    r  = sub ? a - b : a + b;
    bs = sub ? ~b[31] : b[31];
    return (a[31] == bs) && (r[31] != a[31]);
endfunction

function automatic ex_pkg::id_ex_t ref_bubble();
    return '0;
endfunction

// Expected EX/MEM bundle for one registered ID/EX bundle
function automatic ex_pkg::ex_mem_t ref_predict(input ex_pkg::id_ex_t x);
    import ex_pkg::*;
    ex_mem_t    m;
    word_t      a;
    word_t      b;
    word_t      r;
    logic [4:0] sh;
    logic [4:0] sa;
    logic       ov;
    logic       r31;
    a   = x.data_a;
    b   = x.ctrl.alu_src ? x.imm : x.data_b;
    sh  = x.shamt[4:0];
    sa  = x.data_a[4:0];
    ov  = 1'b0;
    r31 = (x.alu_op == OP_JAL);
    case (x.alu_op)
        OP_RTYPE: begin
            case (x.imm[5:0])
                FN_ADD, FN_ADDU: r = a + b;
                FN_SUB, FN_SUBU: r = a - b;
                FN_AND:  r = a & b;
                FN_OR:   r = a | b;
                FN_XOR:  r = a ^ b;
                FN_NOR:  r = ~(a | b);
                FN_SLT:  r = word_t'($signed(a) < $signed(b));
                FN_SLTU: r = word_t'(a < b);
                FN_SLL:  r = b << sh;
                FN_SRL:  r = b >> sh;
                FN_SRA:  r = word_t'($signed(b) >>> sh);
                FN_SLLV: r = b << sa;
                FN_SRLV: r = b >> sa;
                FN_SRAV: r = word_t'($signed(b) >>> sa);
                FN_JALR: r = x.pc + 32'd8;
                default: r = a + b;
            endcase
            if (x.imm[5:0] == FN_ADD) ov = ref_overflow(a, b, 1'b0);
            if (x.imm[5:0] == FN_SUB) ov = ref_overflow(a, b, 1'b1);
        end
        OP_ADDI, OP_LW, OP_SW, OP_LB, OP_SB, OP_LH, OP_SH: begin
            r  = a + b;
            ov = ref_overflow(a, b, 1'b0);
        end
        OP_SLTI:        r = word_t'($signed(a) < $signed(b));
        OP_SLTIU:       r = word_t'(a < b);
        OP_ANDI:        r = a & b;
        OP_ORI:         r = a | b;
        OP_XORI:        r = a ^ b;
        OP_LUI:         r = b << 16;
        OP_BEQ, OP_BNE: r = a - b;
        OP_JAL:         r = x.pc + 32'd8;
        default:        r = a + b;
    endcase
    m.reg_write   = x.ctrl.reg_write;
    m.mem_to_reg  = x.ctrl.mem_to_reg;
    m.mem_read    = x.ctrl.mem_read;
    m.mem_write   = x.ctrl.mem_write;
    m.branch      = x.ctrl.branch;
    m.zero        = (r == '0);
    m.byte_en     = x.ctrl.byte_en;
    m.halfword_en = x.ctrl.halfword_en;
    m.word_en     = x.ctrl.word_en;
    m.r31_ctrl    = r31;
    m.hlt         = x.ctrl.hlt;
    m.oe          = ov;
    m.branch_addr = x.pc + x.imm * 32'd4;
    m.alu_result  = r;
    m.data_b      = x.data_b;
    m.pc          = x.pc;
    m.dest        = r31 ? 5'd31 : (x.ctrl.reg_dest ? x.rd : x.rt);
    return m;
endfunction

`endif

// ==== sim/tb_ex_top.sv ====
`timescale 1ns/1ps

module tb_ex_top;
    import ex_pkg::*;

    `include "ex_ref_model.svh"

    localparam time CLK_PERIOD   = 20;
    localparam time DRIVE_DELAY  = 2;
    localparam int  RESET_CYCLES = 5;
    localparam int  NUM_CYCLES   = 3000;
    localparam int  DRAIN_CYCLES = 4;
    localparam time WATCHDOG_NS  = (RESET_CYCLES + NUM_CYCLES + DRAIN_CYCLES + 50) * CLK_PERIOD;

    logic        clk = 1'b0;
    logic        rst;
    logic        stall;
    logic        flush;
    id_ex_t      id_ex_in;
    ex_mem_t     ex_mem_out;
    id_ex_t      model_id_ex;  // Mirror of the ID/EX register
    ex_mem_t     model_ex_mem; // Expected EX/MEM contents
    logic [31:0] rng_state;

    // R-type weighted heavier than the other opcodes
    opcode_t op_table [0:26] = '{OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE,
        OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_RTYPE, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
        OP_ORI, OP_XORI, OP_LUI, OP_LW, OP_SW, OP_LB, OP_SB, OP_LH, OP_SH, OP_BEQ, OP_BNE, OP_JAL};
    funct_t fn_table [0:16] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
        FN_SLT, FN_SLTU, FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_JALR};

    ex_top UUT (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_stall  (stall),
        .i_flush  (flush),
        .i_id_ex  (id_ex_in),
        .o_ex_mem (ex_mem_out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_error(input string line);
        $display("%s", line);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int unsigned rand_below(input int unsigned n);
        logic [31:0] r;
        r = lcg_next();
        return r[31:12] % n; // Upper bits of the LCG state
    endfunction

    function automatic word_t rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic controls_idle(input ex_mem_t m);
        return !(m.reg_write || m.mem_to_reg || m.mem_read || m.mem_write || m.branch
                 || m.byte_en || m.halfword_en || m.word_en || m.r31_ctrl || m.hlt || m.oe);
    endfunction

    task automatic make_bundle(output id_ex_t b);
        opcode_t     op;
        int unsigned mode;
        word_t       w;
        b        = '0;
        op       = op_table[rand_below(27)];
        mode     = rand_below(8);
        w        = rand_word();
        b.alu_op = op;
        b.pc     = rand_word() & 32'h00FF_FFFC;
        b.data_a = rand_word();
        b.data_b = rand_word();
        b.shamt  = rand_word() & 32'h0000_001F;
        b.imm    = {{16{w[15]}}, w[15:0]};
        b.rt     = reg_idx_t'(rand_below(32));
        b.rd     = reg_idx_t'(rand_below(32));
        if (op inside {OP_ANDI, OP_ORI, OP_XORI}) b.imm[31:16] = '0; // Zero-extended
        if (op == OP_RTYPE) b.imm[5:0] = fn_table[rand_below(17)];
        if (mode == 0) begin
            b.data_a = 32'h7FFF_FFF0; // Signed add overflow
            b.data_b = 32'h0000_0100;
        end else if (mode == 1) begin
            b.data_a = 32'h8000_0000; // Signed subtract overflow
            b.data_b = 32'h0000_0001;
        end else if (mode < 4) begin
            b.data_b = b.data_a;      // Equal operands for zero
        end
        case (op)
            OP_RTYPE:            {b.ctrl.reg_write, b.ctrl.reg_dest} = 2'b11;
            OP_BEQ, OP_BNE:      b.ctrl.branch = 1'b1;
            OP_JAL:              b.ctrl.reg_write = 1'b1;
            OP_LW, OP_LB, OP_LH: begin
                {b.ctrl.reg_write, b.ctrl.mem_to_reg, b.ctrl.mem_read, b.ctrl.alu_src} = 4'hF;
            end
            OP_SW, OP_SB, OP_SH: {b.ctrl.mem_write, b.ctrl.alu_src} = 2'b11;
            default:             {b.ctrl.reg_write, b.ctrl.alu_src} = 2'b11;
        endcase
        b.ctrl.byte_en     = op inside {OP_LB, OP_SB};
        b.ctrl.halfword_en = op inside {OP_LH, OP_SH};
        b.ctrl.word_en     = op inside {OP_LW, OP_SW};
        b.ctrl.hlt         = (rand_below(64) == 0);
    endtask

    always @(posedge clk) begin
        if (rst) begin
            model_id_ex  <= '0;
            model_ex_mem <= '0;
        end else if (!stall) begin
            model_ex_mem <= ref_predict(model_id_ex);
            model_id_ex  <= flush ? ref_bubble() : id_ex_in;
        end
    end

    a_match_model: assert property (@(posedge clk) disable iff (rst) ex_mem_out == model_ex_mem)
        else stop_with_error($sformatf("FAILED at %0t: EX/MEM mismatch, alu_result %h expected %h",
            $time, $sampled(ex_mem_out.alu_result), $sampled(model_ex_mem.alu_result)));

    a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> controls_idle(ex_mem_out))
        else stop_with_error($sformatf("FAILED at %0t: controls active after reset", $time));

    a_flush_bubble: assert property (@(posedge clk) disable iff (rst)
        (!stall && flush) ##1 !stall |=> controls_idle(ex_mem_out))
        else stop_with_error($sformatf("FAILED at %0t: flush left controls active", $time));

    a_stall_hold: assert property (@(posedge clk) disable iff (rst) stall |=> $stable(ex_mem_out))
        else stop_with_error($sformatf("FAILED at %0t: output moved during stall", $time));

    a_link_addr: assert property (@(posedge clk) disable iff (rst) ex_mem_out.r31_ctrl |->
        (ex_mem_out.dest == 5'd31 && ex_mem_out.alu_result == model_ex_mem.pc + 32'd8))
        else stop_with_error($sformatf("FAILED at %0t: JAL link result or dest wrong", $time));

    initial begin
        #(WATCHDOG_NS);
        stop_with_error("Timeout: the simulation ran past its time limit");
    end

    initial begin
        rng_state = 32'd11;
        rst       = 1'b1;
        stall     = 1'b0;
        flush     = 1'b0;
        id_ex_in  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            #(DRIVE_DELAY);
            make_bundle(id_ex_in);
            stall = (rand_below(6) == 0);
            flush = (rand_below(8) == 0);
        end
        @(posedge clk);
        #(DRIVE_DELAY);
        stall = 1'b0; // Let the last items drain
        flush = 1'b0;
        repeat (DRAIN_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        $display("Done: no errors");
        $finish;
    end

endmodule

// ==== verilog/ex_top.sv ====
`timescale 1ns/1ps

module ex_top (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_stall,
    input  logic            i_flush,
    input  ex_pkg::id_ex_t  i_id_ex,
    output ex_pkg::ex_mem_t o_ex_mem
);
    import ex_pkg::*;

    id_ex_t  id_ex_q;  // Registered decode bundle
    ex_mem_t ex_mem_d; // Execute result before EX/MEM

    id_ex_reg u_id_ex_reg (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_stall (i_stall),
        .i_flush (i_flush),
        .i_id_ex (i_id_ex),
        .o_id_ex (id_ex_q)
    );

    ex_stage u_ex_stage (
        .i_id_ex  (id_ex_q),
        .o_ex_mem (ex_mem_d)
    );

    ex_mem_reg u_ex_mem_reg (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_stall  (i_stall),
        .i_ex_mem (ex_mem_d),
        .o_ex_mem (o_ex_mem)
    );

endmodule

// ==== verilog/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_stall,
    input  ex_pkg::ex_mem_t i_ex_mem,
    output ex_pkg::ex_mem_t o_ex_mem
);

    // Reset clears every control bit presented to memory
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex_mem <= '0;
        end else if (!i_stall) begin
            o_ex_mem <= i_ex_mem;
        end
    end

    a_rd_wr_excl: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(o_ex_mem.mem_read && o_ex_mem.mem_write)
    ) else $error("ex_mem_reg: memory read and write both requested");

endmodule

// ==== verilog/id_ex_reg.sv ====
`timescale 1ns/1ps

module id_ex_reg (
    input  logic           i_clk,
    input  logic           i_rst,
    input  logic           i_stall,
    input  logic           i_flush,
    input  ex_pkg::id_ex_t i_id_ex,
    output ex_pkg::id_ex_t o_id_ex
);
    import ex_pkg::*;

    localparam id_ex_t BUBBLE = '0; // Decodes as sll $0,$0,0

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_id_ex <= '0;
        end else if (!i_stall) begin
            if (i_flush) begin
                o_id_ex <= BUBBLE;
            end else begin
                o_id_ex <= i_id_ex;
            end
        end
    end

    a_one_size_en: assert property (
        @(posedge i_clk) disable iff (i_rst)
        $onehot0({o_id_ex.ctrl.byte_en, o_id_ex.ctrl.halfword_en, o_id_ex.ctrl.word_en})
    ) else $error("id_ex_reg: more than one access size enabled");

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  ex_pkg::id_ex_t  i_id_ex,
    output ex_pkg::ex_mem_t o_ex_mem
);
    import ex_pkg::*;

    localparam reg_idx_t LINK_REG = 5'd31;

    funct_t    funct;
    alu_ctrl_e alu_ctrl;
    a_src_e    a_src;
    logic      r31_ctrl;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      zero;
    logic      oe;
    word_t     shifted_imm;
    word_t     branch_addr;
    reg_idx_t  rt_rd;
    reg_idx_t  dest;

    assign funct = i_id_ex.imm[5:0]; // Funct lives in the low immediate bits

    alu_control u_alu_control (
        .i_alu_op   (i_id_ex.alu_op),
        .i_funct    (funct),
        .o_alu_ctrl (alu_ctrl),
        .o_a_src    (a_src),
        .o_r31_ctrl (r31_ctrl)
    );

    always_comb begin
        case (a_src)
            A_SHAMT: alu_a = i_id_ex.shamt;
            A_PC:    alu_a = i_id_ex.pc;
            default: alu_a = i_id_ex.data_a;
        endcase
    end

    assign alu_b = i_id_ex.ctrl.alu_src ? i_id_ex.imm : i_id_ex.data_b;

    alu u_alu (
        .i_a        (alu_a),
        .i_b        (alu_b),
        .i_alu_ctrl (alu_ctrl),
        .o_result   (alu_result),
        .o_zero     (zero),
        .o_oe       (oe)
    );

    // Word offset to byte offset
    assign shifted_imm = {i_id_ex.imm[29:0], 2'b00};
    assign branch_addr = i_id_ex.pc + shifted_imm;

    assign rt_rd = i_id_ex.ctrl.reg_dest ? i_id_ex.rd : i_id_ex.rt;
    assign dest  = r31_ctrl ? LINK_REG : rt_rd;

    always_comb begin
        o_ex_mem.reg_write   = i_id_ex.ctrl.reg_write;
        o_ex_mem.mem_to_reg  = i_id_ex.ctrl.mem_to_reg;
        o_ex_mem.mem_read    = i_id_ex.ctrl.mem_read;
        o_ex_mem.mem_write   = i_id_ex.ctrl.mem_write;
        o_ex_mem.branch      = i_id_ex.ctrl.branch;
        o_ex_mem.zero        = zero;
        o_ex_mem.byte_en     = i_id_ex.ctrl.byte_en;
        o_ex_mem.halfword_en = i_id_ex.ctrl.halfword_en;
        o_ex_mem.word_en     = i_id_ex.ctrl.word_en;
        o_ex_mem.r31_ctrl    = r31_ctrl;
        o_ex_mem.hlt         = i_id_ex.ctrl.hlt;
        o_ex_mem.oe          = oe;
        o_ex_mem.branch_addr = branch_addr;
        o_ex_mem.alu_result  = alu_result;
        o_ex_mem.data_b      = i_id_ex.data_b; // Store data, unshifted
        o_ex_mem.pc          = i_id_ex.pc;
        o_ex_mem.dest        = dest;
    end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  ex_pkg::word_t     i_a,
    input  ex_pkg::word_t     i_b,
    input  ex_pkg::alu_ctrl_e i_alu_ctrl,
    output ex_pkg::word_t     o_result,
    output logic              o_zero,
    output logic              o_oe
);
    import ex_pkg::*;

    word_t      sum;
    word_t      diff;
    logic [4:0] amt;
    logic       add_ov;
    logic       sub_ov;

    assign sum  = i_a + i_b;
    assign diff = i_a - i_b;
    assign amt  = i_a[4:0]; // Shamt or rs, low five bits

    // Same-sign operands giving a result of the other sign
    assign add_ov = (i_a[31] == i_b[31]) && (sum[31] != i_a[31]);
    assign sub_ov = (i_a[31] != i_b[31]) && (diff[31] != i_a[31]);

    always_comb begin
        o_oe = 1'b0;
        case (i_alu_ctrl)
            ALU_ADD: begin
                o_result = sum;
                o_oe     = add_ov;
            end
            ALU_ADDU: o_result = sum;
            ALU_SUB: begin
                o_result = diff;
                o_oe     = sub_ov;
            end
            ALU_SUBU: o_result = diff;
            ALU_AND:  o_result = i_a & i_b;
            ALU_OR:   o_result = i_a | i_b;
            ALU_XOR:  o_result = i_a ^ i_b;
            ALU_NOR:  o_result = ~(i_a | i_b);
            ALU_SLT:  o_result = {31'd0, $signed(i_a) < $signed(i_b)};
            ALU_SLTU: o_result = {31'd0, i_a < i_b};
            ALU_SLL:  o_result = i_b << amt;
            ALU_SRL:  o_result = i_b >> amt;
            ALU_SRA:  o_result = word_t'($signed(i_b) >>> amt);
            ALU_LUI:  o_result = {i_b[15:0], 16'h0000};
            ALU_LINK: o_result = i_a + 32'd8; // Skip the delay slot
            default:  o_result = sum;
        endcase
    end

    assign o_zero = (o_result == '0);

    // Trap flag only for the signed add and subtract
    a_oe_signed_only: assert final (!o_oe || (i_alu_ctrl inside {ALU_ADD, ALU_SUB}))
        else $error("alu: overflow flagged for op %0d", i_alu_ctrl);

endmodule

// ==== verilog/alu_control.sv ====
`timescale 1ns/1ps

module alu_control (
    input  ex_pkg::opcode_t   i_alu_op,
    input  ex_pkg::funct_t    i_funct,
    output ex_pkg::alu_ctrl_e o_alu_ctrl,
    output ex_pkg::a_src_e    o_a_src,
    output logic              o_r31_ctrl
);
    import ex_pkg::*;

    always_comb begin
        o_alu_ctrl = ALU_ADDU;
        o_a_src    = A_REG;
        o_r31_ctrl = 1'b0;
        case (i_alu_op)
            OP_RTYPE: begin
                case (i_funct)
                    FN_ADD:  o_alu_ctrl = ALU_ADD;
                    FN_ADDU: o_alu_ctrl = ALU_ADDU;
                    FN_SUB:  o_alu_ctrl = ALU_SUB;
                    FN_SUBU: o_alu_ctrl = ALU_SUBU;
                    FN_AND:  o_alu_ctrl = ALU_AND;
                    FN_OR:   o_alu_ctrl = ALU_OR;
                    FN_XOR:  o_alu_ctrl = ALU_XOR;
                    FN_NOR:  o_alu_ctrl = ALU_NOR;
                    FN_SLT:  o_alu_ctrl = ALU_SLT;
                    FN_SLTU: o_alu_ctrl = ALU_SLTU;
                    FN_SLL: begin
                        o_alu_ctrl = ALU_SLL;
                        o_a_src    = A_SHAMT;
                    end
                    FN_SRL: begin
                        o_alu_ctrl = ALU_SRL;
                        o_a_src    = A_SHAMT;
                    end
                    FN_SRA: begin
                        o_alu_ctrl = ALU_SRA;
                        o_a_src    = A_SHAMT;
                    end
                    FN_SLLV: o_alu_ctrl = ALU_SLL; // Amount from rs
                    FN_SRLV: o_alu_ctrl = ALU_SRL;
                    FN_SRAV: o_alu_ctrl = ALU_SRA;
                    FN_JALR: begin
                        o_alu_ctrl = ALU_LINK; // Return address, dest is rd
                        o_a_src    = A_PC;
                    end
                    default: o_alu_ctrl = ALU_ADDU;
                endcase
            end
            OP_LW, OP_SW, OP_LB, OP_SB, OP_LH, OP_SH: begin
                o_alu_ctrl = ALU_ADD; // Effective address
            end
            OP_ADDI:  o_alu_ctrl = ALU_ADD;
            OP_ADDIU: o_alu_ctrl = ALU_ADDU;
            OP_SLTI:  o_alu_ctrl = ALU_SLT;
            OP_SLTIU: o_alu_ctrl = ALU_SLTU;
            OP_ANDI:  o_alu_ctrl = ALU_AND;
            OP_ORI:   o_alu_ctrl = ALU_OR;
            OP_XORI:  o_alu_ctrl = ALU_XOR;
            OP_LUI:   o_alu_ctrl = ALU_LUI;
            OP_BEQ, OP_BNE: begin
                o_alu_ctrl = ALU_SUBU; // Compare through zero flag
            end
            OP_JAL: begin
                o_alu_ctrl = ALU_LINK;
                o_a_src    = A_PC;
                o_r31_ctrl = 1'b1;
            end
            default: o_alu_ctrl = ALU_ADDU;
        endcase
    end

endmodule

// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    typedef logic [31:0] word_t;    // Data word, PC or immediate
    typedef logic [4:0]  reg_idx_t; // Register number
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam opcode_t OP_RTYPE = 6'b000000;
    localparam opcode_t OP_JAL   = 6'b000011;
    localparam opcode_t OP_BEQ   = 6'b000100;
    localparam opcode_t OP_BNE   = 6'b000101;
    localparam opcode_t OP_ADDI  = 6'b001000;
    localparam opcode_t OP_ADDIU = 6'b001001;
    localparam opcode_t OP_SLTI  = 6'b001010;
    localparam opcode_t OP_SLTIU = 6'b001011;
    localparam opcode_t OP_ANDI  = 6'b001100;
    localparam opcode_t OP_ORI   = 6'b001101;
    localparam opcode_t OP_XORI  = 6'b001110;
    localparam opcode_t OP_LUI   = 6'b001111;
    localparam opcode_t OP_LB    = 6'b100000;
    localparam opcode_t OP_LH    = 6'b100001;
    localparam opcode_t OP_LW    = 6'b100011;
    localparam opcode_t OP_SB    = 6'b101000;
    localparam opcode_t OP_SH    = 6'b101001;
    localparam opcode_t OP_SW    = 6'b101011;

    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ADD  = 6'b100000;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUB  = 6'b100010;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_SLL  = 4'd10,
        ALU_SRL  = 4'd11,
        ALU_SRA  = 4'd12,
        ALU_LUI  = 4'd13,
        ALU_LINK = 4'd14
    } alu_ctrl_e;

    typedef enum logic [1:0] {
        A_REG   = 2'd0,
        A_SHAMT = 2'd1,
        A_PC    = 2'd2
    } a_src_e;

    typedef struct packed {
        logic reg_write;
        logic mem_to_reg;
        logic mem_read;
        logic mem_write;
        logic branch;
        logic alu_src;
        logic reg_dest;
        logic byte_en;
        logic halfword_en;
        logic word_en;
        logic hlt;
    } ex_ctrl_t;

    typedef struct packed {
        ex_ctrl_t ctrl;
        opcode_t  alu_op;
        word_t    pc;
        word_t    data_a;
        word_t    data_b;
        word_t    imm;   // Already extended by decode
        word_t    shamt;
        reg_idx_t rt;
        reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        logic     reg_write;
        logic     mem_to_reg;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     zero;
        logic     byte_en;
        logic     halfword_en;
        logic     word_en;
        logic     r31_ctrl;
        logic     hlt;
        logic     oe;
        word_t    branch_addr;
        word_t    alu_result;
        word_t    data_b;
        word_t    pc;
        reg_idx_t dest;
    } ex_mem_t;

endpackage
